/* bench/tb_xl_main.sv */
/*
 * testbench top for xl_main: clock, reset, test data reader,
 * byte bus driver, cycle limit and end of run report
 */

`timescale 1ns/100ps

module tb_xl_main;

localparam int          MAX_ENTRIES = 256;
localparam logic [3:0]  OP_WRITE    = 4'h1;     // bus write
localparam logic [3:0]  OP_READ     = 4'h2;     // bus read, compare byte
localparam logic [3:0]  OP_INTR     = 4'h3;     // compare interrupt line
localparam logic [3:0]  OP_WAIT     = 4'h4;     // idle cycles

logic           clk;
logic           reset;
logic           cs_n;
logic           rd_nwr;
logic [3:0]     reg_num;
logic           bytesel;
logic [7:0]     wdata;
wire  [7:0]     rdata;
wire            intr;

// expected value handed to the checker
logic           exp_valid;
logic           exp_intr;       // 1 = interrupt check, 0 = read byte check
logic [7:0]     exp_data;

logic [31:0]    tests [MAX_ENTRIES];    // op, reg, bytesel, data, wait
int             n_entries   = 0;
int             wait_sum    = 0;
int             cycle_limit = 0;        // 0 until tests loaded
int             cycles      = 0;
int             bad_ops     = 0;
int             err_count;
int             chk_count;
int             idx;

xl_main u_xl_main(
    .clk(clk),
    .reset_i(reset),
    .bus_cs_n_i(cs_n),
    .bus_rd_nwr_i(rd_nwr),
    .bus_reg_num_i(reg_num),
    .bus_bytesel_i(bytesel),
    .bus_data_i(wdata),
    .bus_data_o(rdata),
    .bus_intr_o(intr)
);

xl_checker u_xl_checker(
    .clk(clk),
    .reset_i(reset),
    .exp_valid_i(exp_valid),
    .exp_intr_i(exp_intr),
    .exp_data_i(exp_data),
    .bus_data_i(rdata),
    .bus_intr_i(intr),
    .err_count_o(err_count),
    .chk_count_o(chk_count)
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;     // 20 ns period
end

// one access strobe, then idle so strobes are 8 cycles apart
task automatic bus_access(input logic is_read, input logic [3:0] num, input logic bs,
                          input logic [7:0] d);
    @(posedge clk);
    cs_n        <= 1'b0;
    rd_nwr      <= is_read;
    reg_num     <= num;
    bytesel     <= bs;
    wdata       <= is_read ? 8'h00 : d;
    exp_valid   <= is_read;             // reads are always compared
    exp_intr    <= 1'b0;
    exp_data    <= d;
    @(posedge clk);
    cs_n        <= 1'b1;
    rd_nwr      <= 1'b1;
    exp_valid   <= 1'b0;
    repeat (6) @(posedge clk);
endtask

task automatic intr_check(input logic level);
    @(posedge clk);
    exp_valid   <= 1'b1;
    exp_intr    <= 1'b1;
    exp_data    <= {7'b0, level};
    @(posedge clk);
    exp_valid   <= 1'b0;
    repeat (6) @(posedge clk);
endtask

task automatic run_entry(input logic [31:0] entry);
    logic [3:0] op;
    logic [3:0] num;
    logic       bs;
    logic [7:0] d;
    op  = entry[31:28];
    num = entry[27:24];
    bs  = entry[20];
    d   = entry[19:12];
    case (op)
        OP_WRITE:   bus_access(1'b0, num, bs, d);
        OP_READ:    bus_access(1'b1, num, bs, d);
        OP_INTR:    intr_check(d[0]);
        OP_WAIT:    repeat (entry[11:0]) @(posedge clk);
        default: begin
            $display("unknown opcode %0h in the test data at entry %0d", op, idx);
            bad_ops++;
        end
    endcase
endtask

// cycle limit from the length of the tests
always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("summary: %0d checks, %0d errors, %0d bad entries, 1 timeout",
                 chk_count, err_count, bad_ops);
        $display("=== FAIL ===");
        $finish;
    end
end

initial begin
    reset       = 1'b1;
    cs_n        = 1'b1;
    rd_nwr      = 1'b1;
    reg_num     = 4'h0;
    bytesel     = 1'b0;
    wdata       = 8'h00;
    exp_valid   = 1'b0;
    exp_intr    = 1'b0;
    exp_data    = 8'h00;
    for (idx = 0; idx < MAX_ENTRIES; idx++) begin
        tests[idx] = '0;                // opcode 0 marks the end
    end
    $readmemh("bench/xl_tests.txt", tests);
    while (n_entries < MAX_ENTRIES && tests[n_entries][31:28] != 4'h0) begin
        if (tests[n_entries][31:28] == OP_WAIT) begin
            wait_sum = wait_sum + int'(tests[n_entries][11:0]);
        end
        n_entries++;
    end
    cycle_limit = n_entries * 8 + wait_sum + 200;
    if (n_entries == 0) begin
        $display("no test entries were loaded from the data file");
    end

    repeat (5) @(posedge clk);
    reset <= 1'b0;

    for (idx = 0; idx < n_entries; idx++) begin
        run_entry(tests[idx]);
    end
    repeat (4) @(posedge clk);          // let the last compare land

    $display("summary: %0d checks, %0d errors, %0d bad entries, 0 timeouts",
             chk_count, err_count, bad_ops);
    if (err_count == 0 && bad_ops == 0 && chk_count > 0) begin
        $display("=== PASS ===");
    end else begin
        $display("=== FAIL ===");
    end
    $finish;
end

endmodule

/* bench/xl_checker.sv */
/*
 * checker: compares bus read data one cycle after a read strobe,
 * and the interrupt line, against expected values from the testbench
 */

`timescale 1ns/100ps

module xl_checker(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       exp_valid_i,    // one cycle, with the strobe
    input  wire logic       exp_intr_i,     // 1 = interrupt line check
    input  wire logic [7:0] exp_data_i,
    input  wire logic [7:0] bus_data_i,
    input  wire logic       bus_intr_i,
    output int              err_count_o,
    output int              chk_count_o
);

logic           pend;           // compare due this edge
logic           pend_intr;
logic [7:0]     pend_data;

always @(posedge clk) begin
    if (reset_i) begin
        pend        <= 1'b0;
        pend_intr   <= 1'b0;
        pend_data   <= 8'h00;
        err_count_o <= 0;
        chk_count_o <= 0;
    end else begin
        pend        <= exp_valid_i;     // read byte settles after strobe edge
        pend_intr   <= exp_intr_i;
        pend_data   <= exp_data_i;
        if (pend) begin
            chk_count_o <= chk_count_o + 1;
            if (pend_intr) begin
                if (bus_intr_i !== pend_data[0]) begin
                    $display("[ERROR] %0t: interrupt line is %b, expected %b",
                             $time, bus_intr_i, pend_data[0]);
                    err_count_o <= err_count_o + 1;
                end
            end else if (bus_data_i !== pend_data) begin
                $display("[ERROR] %0t: read byte is %02h, expected %02h",
                         $time, bus_data_i, pend_data);
                err_count_o <= err_count_o + 1;
            end
        end
    end
end

endmodule

/* bench/xl_main_sva.sv */
/*
 * assertions on the vram arbiter: exclusive acks, bounded ack latency,
 * blit request held stable until ack
 */

`timescale 1ns/100ps

module xl_main_sva(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           regs_sel_i,
    input  wire logic           regs_ack_i,
    input  wire logic           blit_sel_i,
    input  wire logic           blit_ack_i,
    input  wire xl_pkg::addr_t  blit_addr_i,
    input  wire xl_pkg::word_t  blit_data_i
);

logic [7:0]     regs_wait;      // cycles a select has waited, saturating
logic [7:0]     blit_wait;

always @(posedge clk) begin
    if (reset_i || !regs_sel_i || regs_ack_i) begin
        regs_wait <= 8'd0;
    end else if (regs_wait != 8'hff) begin
        regs_wait <= regs_wait + 8'd1;
    end
    if (reset_i || !blit_sel_i || blit_ack_i) begin
        blit_wait <= 8'd0;
    end else if (blit_wait != 8'hff) begin
        blit_wait <= blit_wait + 8'd1;
    end
end

one_ack: assert property (@(posedge clk) disable iff (reset_i)
    !(regs_ack_i && blit_ack_i))
    else $error("register and blit acks in the same cycle");

regs_latency: assert property (@(posedge clk) disable iff (reset_i)
    regs_wait <= 8'd64)
    else $error("register select not acknowledged within 64 cycles");

blit_latency: assert property (@(posedge clk) disable iff (reset_i)
    blit_wait <= 8'd64)
    else $error("blit select not acknowledged within 64 cycles");

// addr and data move only at the ack edge
blit_stable: assert property (@(posedge clk) disable iff (reset_i)
    (blit_sel_i && !blit_ack_i) |=>
        (blit_sel_i && $stable(blit_addr_i) && $stable(blit_data_i)))
    else $error("blit request changed before its ack");

endmodule

bind xl_vram_arb xl_main_sva u_xl_main_sva(
    .clk(clk),
    .reset_i(reset_i),
    .regs_sel_i(regs_sel_i),
    .regs_ack_i(regs_ack_o),
    .blit_sel_i(blit_sel_i),
    .blit_ack_i(blit_ack_o),
    .blit_addr_i(blit_addr_i),
    .blit_data_i(blit_data_i)
);

/* bench/xl_tests.txt */
// one entry per line, 8 hex digits: op reg bytesel data(2) wait(3)
// op 1 write, 2 read and compare data, 3 compare bus_intr_o to data bit 0, 4 wait cycles
// reset defaults
25000000
25100000
27000000
27100000
2A100000
2F000000
30000000
// xm_addr 0010, three data words, read back with prefetch
10000000
10110000
11012000
11134000
11056000
11178000
1109A000
111BC000
10000000
10110000
21012000
21134000
21056000
21178000
2109A000
211BC000
// guards at 001f and 0024, fill 0020..0023 with a5c3
10000000
1011F000
1101E000
1111F000
10000000
10124000
11024000
11125000
12000000
12120000
140A5000
141C3000
13000000
13104000
40000020
10000000
1011F000
2101E000
2111F000
211C3000
211C3000
211C3000
211C3000
21024000
21125000
// long fill 0080..00bf with 3c5a, register traffic at 0030
12000000
12180000
1403C000
1415A000
13000000
13140000
27101000
10000000
10130000
11043000
11121000
11087000
11165000
10000000
10130000
21043000
21121000
21087000
21165000
40000100
27100000
10000000
10180000
2103C000
2115A000
10000000
101BF000
2103C000
2115A000
// blit interrupt masked in, then cleared
15000000
15101000
25100000
15001000
15100000
30000000
13000000
13102000
40000010
30001000
15001000
15101000
30000000
25100000
25001000
// soft trigger on a masked bit, then mask enabled
15000000
15100000
16000000
16104000
30000000
25104000
15004000
15100000
30001000
25004000

/* run_sim.sh */
#!/bin/sh
# build the xl_main testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_xl_main -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_xl_main)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
    exit 0
fi
exit 1

/* sources.f */
src/xl_pkg.sv
src/xl_reg_decode.sv
src/xl_blit_fill.sv
src/xl_vram_arb.sv
src/xl_intr_result.sv
src/xl_main.sv
bench/xl_main_sva.sv
bench/xl_checker.sv
bench/tb_xl_main.sv

/* src/xl_blit_fill.sv */
/*
 * fill blitter: writes one value over a counted run of vram words,
 * pulses done after the last write ack
 */

`default_nettype none
`timescale 1ns/100ps

module xl_blit_fill(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           blit_start_i,       // ignored while busy
    input  wire xl_pkg::addr_t  blit_addr_i,
    input  wire xl_pkg::word_t  blit_count_i,
    input  wire xl_pkg::word_t  blit_value_i,
    input  wire logic           blit_vram_ack_i,
    output logic                blit_vram_sel_o,
    output xl_pkg::addr_t       blit_vram_addr_o,
    output xl_pkg::word_t       blit_vram_data_o,
    output logic                blit_busy_o,
    output logic                blit_done_o
);

typedef enum logic { ST_IDLE, ST_RUN } state_t;

state_t             state;
xl_pkg::word_t      remain;         // words left incl. current one
logic               start_ok;       // start accepted this cycle

assign start_ok     = (state == ST_IDLE) && blit_start_i;
assign blit_busy_o  = (state == ST_RUN);

always_ff @(posedge clk) begin
    if (reset_i) begin
        state           <= ST_IDLE;
        blit_vram_sel_o <= 1'b0;
        blit_done_o     <= 1'b0;
    end else begin
        blit_done_o     <= 1'b0;
        if (start_ok) begin
            if (blit_count_i == 16'd0) begin
                blit_done_o     <= 1'b1;    // empty fill, just signal
            end else begin
                state           <= ST_RUN;
                blit_vram_sel_o <= 1'b1;
            end
        end else if (blit_busy_o && blit_vram_ack_i && remain == 16'd1) begin
            state           <= ST_IDLE;     // last word written
            blit_vram_sel_o <= 1'b0;
            blit_done_o     <= 1'b1;
        end
    end
end

// address and count step on each ack
always_ff @(posedge clk) begin
    if (start_ok) begin
        blit_vram_addr_o    <= blit_addr_i;
        blit_vram_data_o    <= blit_value_i;
        remain              <= blit_count_i;
    end else if (blit_busy_o && blit_vram_ack_i) begin
        blit_vram_addr_o    <= blit_vram_addr_o + 16'd1;
        remain              <= remain - 16'd1;
    end
end

endmodule
`default_nettype wire

/* src/xl_intr_result.sv */
/*
 * interrupt result: sticky pending status, clears, masked bus interrupt
 */

`default_nettype none
`timescale 1ns/100ps

module xl_intr_result(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire xl_pkg::intr_t  intr_mask_i,
    input  wire xl_pkg::intr_t  intr_clear_i,       // one-cycle clear bits
    input  wire xl_pkg::intr_t  intr_trig_i,        // one-cycle trigger bits
    input  wire logic           blit_done_i,
    output xl_pkg::intr_t       intr_status_o,
    output logic                bus_intr_o
);

xl_pkg::intr_t  intr_events;    // new events this cycle

always_comb begin
    intr_events = intr_trig_i;
    intr_events[xl_pkg::INTR_BLIT] = intr_trig_i[xl_pkg::INTR_BLIT] | blit_done_i;
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        intr_status_o   <= '0;
        bus_intr_o      <= 1'b0;
    end else begin
        intr_status_o   <= (intr_status_o & ~intr_clear_i) | intr_events;   // set wins
        bus_intr_o      <= |(intr_status_o & intr_mask_i);  // one cycle behind status
    end
end

endmodule
`default_nettype wire

/* src/xl_main.sv */
/*
 * video controller main block: register decoder, fill blitter,
 * vram arbiter and interrupt result
 */

`default_nettype none
`timescale 1ns/100ps

module xl_main(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,
    input  wire logic           bus_rd_nwr_i,
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,
    input  wire logic [7:0]     bus_data_i,
    output logic [7:0]          bus_data_o,
    output logic                bus_intr_o
);

// register port to vram
logic               regs_vram_sel;
logic               regs_wr;
xl_pkg::addr_t      regs_addr;
xl_pkg::word_t      regs_data;
logic               regs_vram_ack;
xl_pkg::word_t      vram_rd_data;

// blit port to vram
logic               blit_vram_sel;
xl_pkg::addr_t      blit_addr;
xl_pkg::word_t      blit_data;
logic               blit_vram_ack;

// blit setup and status
logic               blit_start;
xl_pkg::addr_t      blit_addr_val;
xl_pkg::word_t      blit_count_val;
xl_pkg::word_t      blit_value_val;
logic               blit_busy;
logic               blit_done;

// interrupt control
xl_pkg::intr_t      intr_mask;
xl_pkg::intr_t      intr_clear;
xl_pkg::intr_t      intr_trig;
xl_pkg::intr_t      intr_status;

xl_reg_decode u_xl_reg_decode(
    .clk(clk),
    .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i),
    .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),
    .regs_vram_ack_i(regs_vram_ack),
    .vram_rd_data_i(vram_rd_data),
    .blit_busy_i(blit_busy),
    .intr_status_i(intr_status),
    .bus_data_o(bus_data_o),
    .regs_vram_sel_o(regs_vram_sel),
    .regs_wr_o(regs_wr),
    .regs_addr_o(regs_addr),
    .regs_data_o(regs_data),
    .blit_start_o(blit_start),
    .blit_addr_o(blit_addr_val),
    .blit_count_o(blit_count_val),
    .blit_value_o(blit_value_val),
    .intr_mask_o(intr_mask),
    .intr_clear_o(intr_clear),
    .intr_trig_o(intr_trig)
);

xl_blit_fill u_xl_blit_fill(
    .clk(clk),
    .reset_i(reset_i),
    .blit_start_i(blit_start),
    .blit_addr_i(blit_addr_val),
    .blit_count_i(blit_count_val),
    .blit_value_i(blit_value_val),
    .blit_vram_ack_i(blit_vram_ack),
    .blit_vram_sel_o(blit_vram_sel),
    .blit_vram_addr_o(blit_addr),
    .blit_vram_data_o(blit_data),
    .blit_busy_o(blit_busy),
    .blit_done_o(blit_done)
);

xl_vram_arb u_xl_vram_arb(
    .clk(clk),
    .reset_i(reset_i),
    .regs_sel_i(regs_vram_sel),
    .regs_wr_i(regs_wr),
    .regs_addr_i(regs_addr),
    .regs_data_i(regs_data),
    .blit_sel_i(blit_vram_sel),
    .blit_addr_i(blit_addr),
    .blit_data_i(blit_data),
    .regs_ack_o(regs_vram_ack),
    .blit_ack_o(blit_vram_ack),
    .vram_data_o(vram_rd_data)
);

xl_intr_result u_xl_intr_result(
    .clk(clk),
    .reset_i(reset_i),
    .intr_mask_i(intr_mask),
    .intr_clear_i(intr_clear),
    .intr_trig_i(intr_trig),
    .blit_done_i(blit_done),
    .intr_status_o(intr_status),
    .bus_intr_o(bus_intr_o)
);

endmodule
`default_nettype wire

/* src/xl_pkg.sv */
/*
 * shared types and constants for the video controller model:
 * vram word and address types, register numbers, interrupt bits
 */

package xl_pkg;

    // vram geometry
    localparam int VRAM_AW      = 8;                // address bits used to index storage
    localparam int VRAM_DEPTH   = 1 << VRAM_AW;     // 256 words

    typedef logic [15:0] word_t;                    // vram data word
    typedef logic [15:0] addr_t;                    // vram word address, low VRAM_AW bits used

    // interrupt vector and bit positions
    typedef logic [3:0] intr_t;

    localparam int INTR_BLIT    = 0;                // fill finished
    localparam int INTR_SOFT0   = 1;                // software trigger 0
    localparam int INTR_SOFT1   = 2;
    localparam int INTR_SOFT2   = 3;

    // register numbers on the byte bus
    localparam logic [3:0] REG_XM_ADDR      = 4'h0; // vram address, write prefetches
    localparam logic [3:0] REG_XM_DATA      = 4'h1; // vram data, post-increment
    localparam logic [3:0] REG_BLIT_ADDR    = 4'h2; // fill start address
    localparam logic [3:0] REG_BLIT_COUNT   = 4'h3; // fill word count, write starts fill
    localparam logic [3:0] REG_BLIT_VALUE   = 4'h4; // fill value
    localparam logic [3:0] REG_INT_CTRL     = 4'h5; // mask high byte, clear/status low byte
    localparam logic [3:0] REG_INT_TRIG     = 4'h6; // software trigger bits
    localparam logic [3:0] REG_STATUS       = 4'h7; // bit 0 blit busy

endpackage

/* src/xl_reg_decode.sv */
/*
 * byte-lane register bus decoder: word assembly, vram address/data
 * registers with prefetch, blit setup, interrupt control, read data
 */

`default_nettype none
`timescale 1ns/100ps

module xl_reg_decode(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,         // access strobe, active low
    input  wire logic           bus_rd_nwr_i,       // 1 = read
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,      // 0 = even (high) byte
    input  wire logic [7:0]     bus_data_i,
    input  wire logic           regs_vram_ack_i,
    input  wire xl_pkg::word_t  vram_rd_data_i,
    input  wire logic           blit_busy_i,
    input  wire xl_pkg::intr_t  intr_status_i,
    output logic [7:0]          bus_data_o,
    output logic                regs_vram_sel_o,
    output logic                regs_wr_o,
    output xl_pkg::addr_t       regs_addr_o,
    output xl_pkg::word_t       regs_data_o,
    output logic                blit_start_o,
    output xl_pkg::addr_t       blit_addr_o,
    output xl_pkg::word_t       blit_count_o,
    output xl_pkg::word_t       blit_value_o,
    output xl_pkg::intr_t       intr_mask_o,
    output xl_pkg::intr_t       intr_clear_o,
    output xl_pkg::intr_t       intr_trig_o
);

logic               wr_strobe;      // write access this cycle
logic               word_wr;        // odd byte write, word complete
logic               rd_strobe;      // read access this cycle
logic [7:0]         hold_hi;        // even byte holding register
xl_pkg::word_t      wr_word;        // assembled write word
xl_pkg::addr_t      xm_addr;        // vram address, post-increment
xl_pkg::word_t      xm_prefetch;    // last word read from vram
xl_pkg::word_t      rd_word;        // selected register for reads

assign wr_strobe    = ~bus_cs_n_i & ~bus_rd_nwr_i;
assign rd_strobe    = ~bus_cs_n_i & bus_rd_nwr_i;
assign word_wr      = wr_strobe & bus_bytesel_i;
assign wr_word      = { hold_hi, bus_data_i };
assign regs_addr_o  = xm_addr;      // only moves on ack or new access

// read mux, byte picked at the strobe
always_comb begin
    case (bus_reg_num_i)
        xl_pkg::REG_XM_ADDR:    rd_word = xm_addr;
        xl_pkg::REG_XM_DATA:    rd_word = xm_prefetch;
        xl_pkg::REG_BLIT_ADDR:  rd_word = blit_addr_o;
        xl_pkg::REG_BLIT_COUNT: rd_word = blit_count_o;
        xl_pkg::REG_BLIT_VALUE: rd_word = blit_value_o;
        xl_pkg::REG_INT_CTRL:   rd_word = { 4'h0, intr_mask_o, 4'h0, intr_status_i };
        xl_pkg::REG_STATUS:     rd_word = { 15'h0, blit_busy_i };
        default:                rd_word = '0;   // unused registers
    endcase
end

// payload registers
always_ff @(posedge clk) begin
    if (wr_strobe && !bus_bytesel_i) begin
        hold_hi <= bus_data_i;                  // wait for odd byte
    end
    if (regs_vram_ack_i && !regs_wr_o) begin
        xm_prefetch <= vram_rd_data_i;          // read data valid in ack cycle
    end
    if (word_wr) begin
        case (bus_reg_num_i)
            xl_pkg::REG_XM_DATA:    regs_data_o  <= wr_word;
            xl_pkg::REG_BLIT_ADDR:  blit_addr_o  <= wr_word;
            xl_pkg::REG_BLIT_COUNT: blit_count_o <= wr_word;
            xl_pkg::REG_BLIT_VALUE: blit_value_o <= wr_word;
            default: ;
        endcase
    end
end

// control: vram request, pulses, mask, read byte
always_ff @(posedge clk) begin
    if (reset_i) begin
        regs_vram_sel_o <= 1'b0;
        regs_wr_o       <= 1'b0;
        xm_addr         <= '0;
        blit_start_o    <= 1'b0;
        intr_mask_o     <= '0;
        intr_clear_o    <= '0;
        intr_trig_o     <= '0;
        bus_data_o      <= 8'h00;
    end else begin
        blit_start_o    <= 1'b0;            // one-cycle pulses
        intr_clear_o    <= '0;
        intr_trig_o     <= '0;

        if (regs_vram_ack_i) begin
            if (regs_wr_o) begin
                xm_addr     <= xm_addr + 16'd1; // write done, keep sel for prefetch
                regs_wr_o   <= 1'b0;
            end else begin
                regs_vram_sel_o <= 1'b0;        // prefetch done
            end
        end

        if (word_wr) begin
            case (bus_reg_num_i)
                xl_pkg::REG_XM_ADDR: begin
                    xm_addr         <= wr_word;
                    regs_vram_sel_o <= 1'b1;    // prefetch new address
                    regs_wr_o       <= 1'b0;
                end
                xl_pkg::REG_XM_DATA: begin
                    regs_vram_sel_o <= 1'b1;    // write, then prefetch
                    regs_wr_o       <= 1'b1;
                end
                xl_pkg::REG_BLIT_COUNT: blit_start_o <= 1'b1;
                xl_pkg::REG_INT_CTRL: begin
                    intr_mask_o     <= hold_hi[3:0];
                    intr_clear_o    <= bus_data_i[3:0];
                end
                xl_pkg::REG_INT_TRIG: begin
                    intr_trig_o[xl_pkg::INTR_BLIT]  <= bus_data_i[xl_pkg::INTR_BLIT];
                    intr_trig_o[xl_pkg::INTR_SOFT0] <= bus_data_i[xl_pkg::INTR_SOFT0];
                    intr_trig_o[xl_pkg::INTR_SOFT1] <= bus_data_i[xl_pkg::INTR_SOFT1];
                    intr_trig_o[xl_pkg::INTR_SOFT2] <= bus_data_i[xl_pkg::INTR_SOFT2];
                end
                default: ;
            endcase
        end

        if (rd_strobe) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];  // held till next read
            if (bus_reg_num_i == xl_pkg::REG_XM_DATA && bus_bytesel_i) begin
                xm_addr         <= xm_addr + 16'd1; // odd byte read advances
                regs_vram_sel_o <= 1'b1;
                regs_wr_o       <= 1'b0;
            end
        end
    end
end

endmodule
`default_nettype wire

/* src/xl_vram_arb.sv */
/*
 * vram storage with two-port priority arbiter,
 * register port first, blit port write only
 */

`default_nettype none
`timescale 1ns/100ps

module xl_vram_arb(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           regs_sel_i,
    input  wire logic           regs_wr_i,
    input  wire xl_pkg::addr_t  regs_addr_i,
    input  wire xl_pkg::word_t  regs_data_i,
    input  wire logic           blit_sel_i,
    input  wire xl_pkg::addr_t  blit_addr_i,
    input  wire xl_pkg::word_t  blit_data_i,
    output logic                regs_ack_o,
    output logic                blit_ack_o,
    output xl_pkg::word_t       vram_data_o         // valid with regs_ack_o
);

xl_pkg::word_t  vram [xl_pkg::VRAM_DEPTH];  // word storage
logic           regs_gnt;
logic           blit_gnt;

// a select still high in its ack cycle is not granted again
assign regs_gnt = regs_sel_i && !regs_ack_o;
assign blit_gnt = blit_sel_i && !blit_ack_o && !regs_sel_i;   // only with no register request

// single port array, one access per cycle
always_ff @(posedge clk) begin
    if (regs_gnt) begin
        if (regs_wr_i) begin
            vram[regs_addr_i[xl_pkg::VRAM_AW-1:0]] <= regs_data_i;
        end else begin
            vram_data_o <= vram[regs_addr_i[xl_pkg::VRAM_AW-1:0]];
        end
    end else if (blit_gnt) begin
        vram[blit_addr_i[xl_pkg::VRAM_AW-1:0]] <= blit_data_i;
    end
end

// acks one cycle after grant
always_ff @(posedge clk) begin
    if (reset_i) begin
        regs_ack_o  <= 1'b0;
        blit_ack_o  <= 1'b0;
    end else begin
        regs_ack_o  <= regs_gnt;
        blit_ack_o  <= blit_gnt;
    end
end

endmodule
`default_nettype wire
